/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = dcache_tb
FLIST = flist.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* flist.f */
hw/dcache_geom_pkg.sv
hw/dcache_bus_pkg.sv
hw/dcache_lookup.sv
hw/dcache_miss_queue.sv
hw/dcache_line_array.sv
hw/dcache_top.sv
tests/dcache_checker.sv
tests/dcache_tb.sv

/* hw/dcache_bus_pkg.sv */
package dcache_bus_pkg;

    import dcache_geom_pkg::*;

    // tag handed out by memory on acceptance
    typedef logic [3:0] mem_tag_t;

    // zero is never granted, it marks an idle response bus
    localparam mem_tag_t MEM_TAG_NONE = 4'd0;

    typedef enum logic {
        MEM_LOAD  = 1'b0,
        MEM_STORE = 1'b1
    } mem_cmd_e;

    // request toward memory, block only matters for stores
    typedef struct packed {
        logic     valid;
        mem_cmd_e cmd;
        addr_t    addr;
        block_t   block;
    } mem_req_t;

    // data returned by memory for a granted load
    typedef struct packed {
        mem_tag_t tag;
        block_t   block;
    } mem_resp_t;

    // load or store from the core
    typedef struct packed {
        logic         valid;
        logic         write;
        access_size_e size;
        addr_t        addr;
        word_t        wdata;
    } cpu_access_t;

    // load just accepted by memory, tells the array which tag to expect
    typedef struct packed {
        logic     valid;
        addr_t    addr;
        mem_tag_t tag;
    } issued_load_t;

endpackage

/* hw/dcache_geom_pkg.sv */
package dcache_geom_pkg;

    // byte address as seen by the core
    typedef logic [31:0] addr_t;

    // one data word of the core
    typedef logic [31:0] word_t;

    // a block holds two words, word 0 sits in the low half
    typedef logic [63:0] block_t;

    // per-line age, saturates at all ones
    typedef logic [7:0] lru_age_t;

    // byte offset inside a block
    localparam int BLOCK_OFFSET_W = 3;

    // width of a core access
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

endpackage

/* hw/dcache_line_array.sv */
`timescale 1ns/1ps

module dcache_line_array
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
#(
    parameter int NUM_SETS = 4,
    parameter int NUM_WAYS = 2,
    localparam int SET_W = $clog2(NUM_SETS),
    localparam int TAG_W = $bits(addr_t) - BLOCK_OFFSET_W - SET_W,
    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1,
    localparam int VIEW_W = TAG_W + 3 + $bits(lru_age_t) + $bits(block_t),
    localparam int UPDATE_W = 3 + WAY_W + TAG_W + $bits(block_t)
) (
    input  logic                       clock,
    input  logic                       reset,
    input  addr_t                      access_addr,
    input  logic [UPDATE_W-1:0]        line_update,
    input  issued_load_t               issued_load,
    input  mem_resp_t                  mem_resp,
    output logic [NUM_WAYS*VIEW_W-1:0] set_lines
);

    typedef logic [SET_W-1:0] set_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [WAY_W-1:0] way_t;

    // pending waits for a memory tag, waiting waits for the data
    typedef enum logic [1:0] {
        LINE_INVALID,
        LINE_PENDING,
        LINE_WAITING,
        LINE_VALID
    } line_state_e;

    typedef struct packed {
        tag_t        tag;
        line_state_e state;
        logic        dirty;
        lru_age_t    age;
        mem_tag_t    mtag;
        block_t      block;
    } line_t;

    typedef struct packed {
        tag_t     tag;
        logic     valid;
        logic     busy;
        logic     dirty;
        lru_age_t age;
        block_t   block;
    } line_view_t;

    typedef struct packed {
        logic   touch;
        logic   write;
        logic   reserve;
        way_t   way;
        tag_t   tag;
        block_t block;
    } line_update_t;

    line_t lines [NUM_SETS][NUM_WAYS];
    line_t lines_n [NUM_SETS][NUM_WAYS];
    line_view_t [NUM_WAYS-1:0] ways;
    line_update_t update;
    set_t acc_set;
    set_t load_set;
    tag_t load_tag;

    assign update = line_update;
    assign set_lines = ways;
    assign acc_set = access_addr[BLOCK_OFFSET_W +: SET_W];
    assign load_set = issued_load.addr[BLOCK_OFFSET_W +: SET_W];
    assign load_tag = issued_load.addr[BLOCK_OFFSET_W + SET_W +: TAG_W];

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            ways[w].tag = lines[acc_set][w].tag;
            ways[w].valid = (lines[acc_set][w].state == LINE_VALID);
            ways[w].busy = (lines[acc_set][w].state == LINE_PENDING)
                           || (lines[acc_set][w].state == LINE_WAITING);
            ways[w].dirty = lines[acc_set][w].dirty;
            ways[w].age = lines[acc_set][w].age;
            ways[w].block = lines[acc_set][w].block;
        end
    end

    always_comb begin
        lines_n = lines;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (lines[s][w].state != LINE_INVALID && lines[s][w].age != '1) begin
                    lines_n[s][w].age = lines[s][w].age + lru_age_t'(1);
                end
                // memory granted a tag for this line's load
                if (lines[s][w].state == LINE_PENDING && issued_load.valid
                        && set_t'(s) == load_set && lines[s][w].tag == load_tag) begin
                    lines_n[s][w].mtag = issued_load.tag;
                    lines_n[s][w].state = LINE_WAITING;
                end
                // refill
                if (lines[s][w].state == LINE_WAITING && mem_resp.tag != MEM_TAG_NONE
                        && lines[s][w].mtag == mem_resp.tag) begin
                    lines_n[s][w].block = mem_resp.block;
                    lines_n[s][w].state = LINE_VALID;
                    lines_n[s][w].dirty = 1'b0;
                    lines_n[s][w].age = '0;
                    lines_n[s][w].mtag = MEM_TAG_NONE;
                end
            end
        end
        if (update.touch) begin
            lines_n[acc_set][update.way].age = '0;
            if (update.write) begin
                lines_n[acc_set][update.way].block = update.block;
                lines_n[acc_set][update.way].dirty = 1'b1;
            end
        end
        if (update.reserve) begin
            lines_n[acc_set][update.way].tag = update.tag;
            lines_n[acc_set][update.way].state = LINE_PENDING;
            lines_n[acc_set][update.way].dirty = 1'b0;
            lines_n[acc_set][update.way].age = '0;
            lines_n[acc_set][update.way].mtag = MEM_TAG_NONE;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    lines[s][w].state <= LINE_INVALID;
                    lines[s][w].dirty <= 1'b0;
                    lines[s][w].age <= '0;
                    lines[s][w].mtag <= MEM_TAG_NONE;
                end
            end
        end else begin
            lines <= lines_n;
        end
    end

endmodule

/* hw/dcache_lookup.sv */
`timescale 1ns/1ps

module dcache_lookup
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
#(
    parameter int NUM_SETS = 4,
    parameter int NUM_WAYS = 2,
    localparam int SET_W = $clog2(NUM_SETS),
    localparam int TAG_W = $bits(addr_t) - BLOCK_OFFSET_W - SET_W,
    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1,
    localparam int VIEW_W = TAG_W + 3 + $bits(lru_age_t) + $bits(block_t),
    localparam int UPDATE_W = 3 + WAY_W + TAG_W + $bits(block_t)
) (
    input  cpu_access_t                access,
    input  logic [NUM_WAYS*VIEW_W-1:0] set_lines,
    input  logic                       queue_space,
    output logic                       hit,
    output word_t                      rdata,
    output logic [UPDATE_W-1:0]        line_update,
    output mem_req_t                   push_store,
    output mem_req_t                   push_load
);

    typedef logic [SET_W-1:0] set_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [WAY_W-1:0] way_t;

    typedef struct packed {
        tag_t     tag;
        logic     valid;
        logic     busy;
        logic     dirty;
        lru_age_t age;
        block_t   block;
    } line_view_t;

    typedef struct packed {
        logic   touch;
        logic   write;
        logic   reserve;
        way_t   way;
        tag_t   tag;
        block_t block;
    } line_update_t;

    line_view_t [NUM_WAYS-1:0] ways;
    line_update_t update;
    set_t acc_set;
    tag_t acc_tag;
    logic hit_found;
    way_t hit_way;
    logic in_flight;
    logic empty_found;
    way_t empty_way;
    logic old_found;
    way_t old_way;
    lru_age_t old_age;
    way_t victim_way;
    line_view_t victim;
    logic start_miss;
    block_t hit_block;
    block_t merged;

    assign ways = set_lines;
    assign line_update = update;
    assign acc_set = access.addr[BLOCK_OFFSET_W +: SET_W];
    assign acc_tag = access.addr[BLOCK_OFFSET_W + SET_W +: TAG_W];

    always_comb begin
        hit_found = 1'b0;
        hit_way = '0;
        in_flight = 1'b0;
        empty_found = 1'b0;
        empty_way = '0;
        old_found = 1'b0;
        old_way = '0;
        old_age = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ways[w].tag == acc_tag) begin
                if (ways[w].valid) begin
                    hit_found = 1'b1;
                    hit_way = way_t'(w);
                end
                // block already on its way from memory
                if (ways[w].busy) begin
                    in_flight = 1'b1;
                end
            end
            if (!ways[w].valid && !ways[w].busy && !empty_found) begin
                empty_found = 1'b1;
                empty_way = way_t'(w);
            end
            // oldest valid way, lowest index wins a tie
            if (ways[w].valid && (!old_found || ways[w].age > old_age)) begin
                old_found = 1'b1;
                old_way = way_t'(w);
                old_age = ways[w].age;
            end
        end
    end

    assign victim_way = empty_found ? empty_way : old_way;
    assign victim = ways[victim_way];
    assign hit = access.valid && hit_found;
    assign start_miss = access.valid && !hit_found && !in_flight
                        && (empty_found || old_found) && queue_space;

    assign hit_block = ways[hit_way].block;
    assign rdata = access.addr[2] ? hit_block[63:32] : hit_block[31:0];

    // store data lands at its byte lanes of the block
    always_comb begin
        merged = hit_block;
        case (access.size)
            SIZE_BYTE: merged[{access.addr[2:0], 3'b000} +: 8] = access.wdata[7:0];
            SIZE_HALF: merged[{access.addr[2:1], 4'b0000} +: 16] = access.wdata[15:0];
            SIZE_WORD: merged[{access.addr[2], 5'b00000} +: 32] = access.wdata;
            default: merged = hit_block;
        endcase
    end

    always_comb begin
        update.touch = hit;
        update.write = hit && access.write;
        update.reserve = start_miss;
        update.way = hit_found ? hit_way : victim_way;
        update.tag = acc_tag;
        update.block = merged;
    end

    // dirty victim goes out ahead of the refill
    always_comb begin
        push_store.valid = start_miss && victim.valid && victim.dirty;
        push_store.cmd = MEM_STORE;
        push_store.addr = {victim.tag, acc_set, {BLOCK_OFFSET_W{1'b0}}};
        push_store.block = victim.block;
        push_load.valid = start_miss;
        push_load.cmd = MEM_LOAD;
        push_load.addr = {access.addr[$bits(addr_t)-1:BLOCK_OFFSET_W],
                          {BLOCK_OFFSET_W{1'b0}}};
        push_load.block = '0;
    end

endmodule

/* hw/dcache_miss_queue.sv */
`timescale 1ns/1ps

module dcache_miss_queue
    import dcache_bus_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4,
    localparam int PTR_W = $clog2(QUEUE_DEPTH),
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1)
) (
    input  logic         clock,
    input  logic         reset,
    input  mem_req_t     push_store,
    input  mem_req_t     push_load,
    input  logic         mem_accept,
    input  mem_tag_t     mem_accept_tag,
    output mem_req_t     mem_req,
    output logic         queue_space,
    output issued_load_t issued_load
);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] count_t;

    mem_req_t entries [QUEUE_DEPTH];
    ptr_t head;
    ptr_t tail;
    count_t count;
    count_t num_push;
    logic pop;

    // wrap also works for depths that are not a power of two
    function automatic ptr_t ptr_inc(ptr_t ptr);
        return (ptr == ptr_t'(QUEUE_DEPTH - 1)) ? '0 : ptr + ptr_t'(1);
    endfunction

    always_comb begin
        mem_req = entries[head];
        mem_req.valid = (count != '0);
    end

    assign pop = mem_accept && mem_req.valid;
    assign num_push = count_t'(push_store.valid) + count_t'(push_load.valid);
    assign queue_space = (count <= count_t'(QUEUE_DEPTH - 2));

    always_comb begin
        issued_load.valid = pop && (mem_req.cmd == MEM_LOAD);
        issued_load.addr = mem_req.addr;
        issued_load.tag = mem_accept_tag;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (pop) begin
                head <= ptr_inc(head);
            end
            if (push_store.valid && push_load.valid) begin
                tail <= ptr_inc(ptr_inc(tail));
            end else if (push_store.valid || push_load.valid) begin
                tail <= ptr_inc(tail);
            end
            count <= count + num_push - count_t'(pop);
        end
    end

    // writeback first, then the load behind it
    always_ff @(posedge clock) begin
        if (push_store.valid) begin
            entries[tail] <= push_store;
            if (push_load.valid) begin
                entries[ptr_inc(tail)] <= push_load;
            end
        end else if (push_load.valid) begin
            entries[tail] <= push_load;
        end
    end

endmodule

/* hw/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
#(
    parameter int NUM_SETS = 4,
    parameter int NUM_WAYS = 2,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic        clock,
    input  logic        reset,
    input  cpu_access_t access,
    input  logic        mem_accept,
    input  mem_tag_t    mem_accept_tag,
    input  mem_resp_t   mem_resp,
    output logic        hit,
    output word_t       rdata,
    output mem_req_t    mem_req
);

    // widths of the line view and line update buses
    localparam int SET_W = $clog2(NUM_SETS);
    localparam int TAG_W = $bits(addr_t) - BLOCK_OFFSET_W - SET_W;
    localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
    localparam int VIEW_W = TAG_W + 3 + $bits(lru_age_t) + $bits(block_t);
    localparam int UPDATE_W = 3 + WAY_W + TAG_W + $bits(block_t);

    logic [NUM_WAYS*VIEW_W-1:0] set_lines;
    logic [UPDATE_W-1:0] line_update;
    mem_req_t push_store;
    mem_req_t push_load;
    logic queue_space;
    issued_load_t issued_load;

    dcache_lookup #(
        .NUM_SETS(NUM_SETS),
        .NUM_WAYS(NUM_WAYS)
    ) lookup (
        .access(access),
        .set_lines(set_lines),
        .queue_space(queue_space),
        .hit(hit),
        .rdata(rdata),
        .line_update(line_update),
        .push_store(push_store),
        .push_load(push_load)
    );

    dcache_miss_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) miss_queue (
        .clock(clock),
        .reset(reset),
        .push_store(push_store),
        .push_load(push_load),
        .mem_accept(mem_accept),
        .mem_accept_tag(mem_accept_tag),
        .mem_req(mem_req),
        .queue_space(queue_space),
        .issued_load(issued_load)
    );

    dcache_line_array #(
        .NUM_SETS(NUM_SETS),
        .NUM_WAYS(NUM_WAYS)
    ) line_array (
        .clock(clock),
        .reset(reset),
        .access_addr(access.addr),
        .line_update(line_update),
        .issued_load(issued_load),
        .mem_resp(mem_resp),
        .set_lines(set_lines)
    );

endmodule

/* tests/dcache_checker.sv */
`timescale 1ns/1ps

module dcache_checker
    import dcache_bus_pkg::*;
(
    input logic     clock,
    input logic     reset,
    input mem_req_t mem_req,
    input logic     mem_accept,
    input mem_tag_t mem_accept_tag
);

    // head of the queue holds until memory takes it
    req_stable: assert property (@(posedge clock) disable iff (reset)
        (mem_req.valid && !mem_accept) |=> $stable(mem_req))
        else $error("mem_req changed while waiting for acceptance");

    accept_legal: assert property (@(posedge clock) disable iff (reset)
        mem_accept |-> (mem_req.valid && mem_accept_tag != MEM_TAG_NONE))
        else $error("mem_accept without a valid request or with tag zero");

    idle_after_reset: assert property (@(posedge clock)
        $past(reset) |-> !mem_req.valid)
        else $error("mem_req.valid high right after reset");

endmodule

bind dcache_top dcache_checker checker_inst (
    .clock(clock),
    .reset(reset),
    .mem_req(mem_req),
    .mem_accept(mem_accept),
    .mem_accept_tag(mem_accept_tag)
);

/* tests/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
();

    logic clock;
    logic reset;
    cpu_access_t access;
    logic mem_accept;
    mem_tag_t mem_accept_tag;
    mem_resp_t mem_resp;
    logic hit;
    word_t rdata;
    mem_req_t mem_req;

    // memory model state
    logic [31:0] lfsr_state;
    block_t memory [addr_t];
    block_t golden [addr_t];
    mem_cmd_e log_cmd [$];
    addr_t log_addr [$];
    block_t log_block [$];
    mem_tag_t resp_tag [$];
    block_t resp_block [$];
    int resp_due [$];
    logic hold_accept;
    logic reverse_order;
    int cycle;
    int accept_wait;
    mem_tag_t next_tag;

    dcache_top #(
        .NUM_SETS(4),
        .NUM_WAYS(2),
        .QUEUE_DEPTH(4)
    ) UUT (
        .clock(clock),
        .reset(reset),
        .access(access),
        .mem_accept(mem_accept),
        .mem_accept_tag(mem_accept_tag),
        .mem_resp(mem_resp),
        .hit(hit),
        .rdata(rdata),
        .mem_req(mem_req)
    );

    always #50 clock = ~clock;

    function automatic block_t pattern(addr_t baddr);
        return {baddr ^ 32'h5a5a0f0f, ~baddr + 32'h01234567};
    endfunction

    function automatic int random_bits(int n);
        int value;
        logic lsb;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 32'h80200003;
            end
            value = (value << 1) | int'(lsb);
        end
        return value;
    endfunction

    function automatic block_t mem_block(addr_t baddr);
        return memory.exists(baddr) ? memory[baddr] : pattern(baddr);
    endfunction

    function automatic block_t golden_block(addr_t baddr);
        return golden.exists(baddr) ? golden[baddr] : pattern(baddr);
    endfunction

    function automatic word_t golden_word(addr_t addr);
        block_t blk;
        blk = golden_block({addr[31:3], 3'b000});
        return addr[2] ? blk[63:32] : blk[31:0];
    endfunction

    task automatic golden_store(addr_t addr, access_size_e size, word_t wdata);
        block_t blk;
        int nbytes;
        int first;
        blk = golden_block({addr[31:3], 3'b000});
        nbytes = (size == SIZE_BYTE) ? 1 : ((size == SIZE_HALF) ? 2 : 4);
        first = int'(addr[2:0]);
        for (int i = 0; i < nbytes; i++) begin
            blk[(first + i) * 8 +: 8] = wdata[i * 8 +: 8];
        end
        golden[{addr[31:3], 3'b000}] = blk;
    endtask

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    // taken at the edge where memory accepted the head
    task automatic record_acceptance();
        log_cmd.push_back(mem_req.cmd);
        log_addr.push_back(mem_req.addr);
        log_block.push_back(mem_req.block);
        if (mem_req.cmd == MEM_STORE) begin
            memory[mem_req.addr] = mem_req.block;
        end else begin
            resp_tag.push_back(mem_accept_tag);
            resp_block.push_back(mem_block(mem_req.addr));
            resp_due.push_back(cycle + random_bits(2));
        end
        next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        accept_wait = random_bits(2);
    endtask

    task automatic drive_memory();
        int pick;
        mem_accept = 1'b0;
        mem_accept_tag = next_tag;
        mem_resp.tag = MEM_TAG_NONE;
        mem_resp.block = '0;
        if (mem_req.valid && !hold_accept) begin
            if (accept_wait == 0) begin
                mem_accept = 1'b1;
            end else begin
                accept_wait--;
            end
        end
        pick = -1;
        if (reverse_order) begin
            // newest first once two loads are out
            if (resp_tag.size() >= 2) begin
                pick = resp_tag.size() - 1;
                reverse_order = 1'b0;
            end
        end else if (resp_tag.size() > 0 && resp_due[0] <= cycle) begin
            pick = 0;
        end
        if (pick >= 0) begin
            mem_resp.tag = resp_tag[pick];
            mem_resp.block = resp_block[pick];
            resp_tag.delete(pick);
            resp_block.delete(pick);
            resp_due.delete(pick);
        end
    endtask

    always @(posedge clock) begin
        if (!reset) begin
            if (mem_accept && mem_req.valid) begin
                record_acceptance();
            end
            cycle++;
        end
        #1;
        drive_memory();
    end

    task automatic drive_access(addr_t addr, logic write, access_size_e size, word_t wdata);
        access.valid = 1'b1;
        access.write = write;
        access.size = size;
        access.addr = addr;
        access.wdata = wdata;
    endtask

    // mode flags change away from the model's drive point
    task automatic set_mode(logic hold, logic reverse);
        @(negedge clock);
        hold_accept = hold;
        reverse_order = reverse;
        @(posedge clock);
        #1;
    endtask

    task automatic access_until_hit(addr_t addr, logic write, access_size_e size,
                                    word_t wdata, output word_t data);
        int waited;
        drive_access(addr, write, size, wdata);
        waited = 0;
        @(negedge clock);
        while (!hit) begin
            if (waited == 200) begin
                report_failure($sformatf("access to %h never hit before timeout", addr));
            end
            waited++;
            @(negedge clock);
        end
        data = rdata;
        @(posedge clock);
        #1;
        access = '0;
        if (write) begin
            golden_store(addr, size, wdata);
        end
    endtask

    task automatic one_cycle_access(addr_t addr);
        drive_access(addr, 1'b0, SIZE_WORD, '0);
        @(posedge clock);
        #1;
        access = '0;
    endtask

    task automatic check_read(addr_t addr);
        word_t data;
        access_until_hit(addr, 1'b0, SIZE_WORD, '0, data);
        assert (data == golden_word(addr))
        else report_failure($sformatf("Error: rdata at %h expected %h got %h",
                                      addr, golden_word(addr), data));
    endtask

    task automatic store_value(addr_t addr, access_size_e size, word_t wdata);
        word_t data;
        access_until_hit(addr, 1'b1, size, wdata, data);
    endtask

    task automatic check_request(int idx, mem_cmd_e cmd, addr_t addr);
        assert (log_cmd.size() > idx)
        else report_failure("expected memory request never arrived");
        assert (log_cmd[idx] == cmd)
        else report_failure($sformatf("Error: mem_req.cmd expected %h got %h",
                                      cmd, log_cmd[idx]));
        assert (log_addr[idx] == addr)
        else report_failure($sformatf("Error: mem_req.addr expected %h got %h",
                                      addr, log_addr[idx]));
    endtask

    function automatic int count_requests(int mark, addr_t addr);
        int n;
        n = 0;
        for (int i = mark; i < log_addr.size(); i++) begin
            if (log_addr[i] == addr) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic test_first_load();
        int mark;
        for (int i = 0; i < 3; i++) begin
            assert (!mem_req.valid)
            else report_failure("Error: mem_req.valid expected 0 got 1");
            @(posedge clock);
            #1;
        end
        mark = log_cmd.size();
        // no line is valid yet
        drive_access(32'h104, 1'b0, SIZE_WORD, '0);
        #1;
        assert (!hit) else report_failure("Error: hit expected 0 got 1");
        assert (!mem_req.valid)
        else report_failure("Error: mem_req.valid expected 0 got 1");
        check_read(32'h104);
        check_request(mark, MEM_LOAD, 32'h100);
    endtask

    task automatic test_store_merge();
        store_value(32'h104, SIZE_WORD, 32'hcafe1234);
        store_value(32'h106, SIZE_HALF, 32'h0000beef);
        store_value(32'h101, SIZE_BYTE, 32'h0000005a);
        store_value(32'h107, SIZE_BYTE, 32'h00000011);
        check_read(32'h100);
        check_read(32'h104);
    endtask

    task automatic test_replacement();
        int mark;
        block_t victim;
        check_read(32'h200);
        check_read(32'h100);
        mark = log_cmd.size();
        check_read(32'h300);
        assert (log_cmd.size() == mark + 1)
        else report_failure("clean victim produced an extra memory request");
        check_request(mark, MEM_LOAD, 32'h300);
        // 0x100 was touched last and must still be resident
        mark = log_cmd.size();
        check_read(32'h100);
        assert (log_cmd.size() == mark)
        else report_failure("recently used block was evicted");
        check_read(32'h304);
        victim = golden_block(32'h100);
        mark = log_cmd.size();
        check_read(32'h400);
        check_request(mark, MEM_STORE, 32'h100);
        assert (log_block[mark] == victim)
        else report_failure($sformatf("Error: mem_req.block expected %h got %h",
                                      victim, log_block[mark]));
        check_request(mark + 1, MEM_LOAD, 32'h400);
        check_read(32'h300);
        check_read(32'h100);
    endtask

    task automatic test_held_acceptance();
        int mark;
        addr_t addrs [4];
        addrs = '{32'h008, 32'h010, 32'h018, 32'h028};
        set_mode(1'b1, 1'b0);
        mark = log_cmd.size();
        foreach (addrs[i]) begin
            one_cycle_access(addrs[i]);
        end
        repeat (5) @(posedge clock);
        #1;
        assert (mem_req.valid) else report_failure("Error: mem_req.valid expected 1 got 0");
        // first miss stays at the head
        assert (mem_req.addr == addrs[0])
        else report_failure($sformatf("Error: mem_req.addr expected %h got %h",
                                      addrs[0], mem_req.addr));
        set_mode(1'b0, 1'b0);
        foreach (addrs[i]) begin
            check_read(addrs[i]);
            check_read(addrs[i] + 32'h4);
        end
        foreach (addrs[i]) begin
            assert (count_requests(mark, addrs[i]) == 1)
            else report_failure($sformatf("block %h was not requested exactly once", addrs[i]));
        end
    endtask

    task automatic test_reverse_return();
        set_mode(1'b0, 1'b1);
        one_cycle_access(32'h030);
        one_cycle_access(32'h038);
        check_read(32'h034);
        check_read(32'h038);
        assert (!reverse_order)
        else report_failure("two loads were never outstanding together");
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        access = '0;
        mem_accept = 1'b0;
        mem_accept_tag = MEM_TAG_NONE;
        mem_resp = '0;
        lfsr_state = 32'h3f51a1fd;
        hold_accept = 1'b0;
        reverse_order = 1'b0;
        cycle = 0;
        accept_wait = 0;
        next_tag = 4'd1;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        test_first_load();
        test_store_merge();
        test_replacement();
        test_held_acceptance();
        test_reverse_return();
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
